// ==== files.f ====
hdl/mem_pkg.sv
hdl/axi_pkg.sv
hdl/axi_lite_if.sv
hdl/mem_cmd_if.sv
hdl/cmd_fifo.sv
hdl/axi_lite_master.sv
hdl/axi_lite_sram.sv
hdl/mem_subsys_top.sv
test/mem_subsys_sva.sv
test/mem_subsys_tb.sv

// ==== hdl/axi_lite_if.sv ====
`default_nettype none

interface axi_lite_if;

	// write address channel
	logic             awvalid;
	logic             awready;
	mem_pkg::addr_t   awaddr;

	// write data channel
	logic             wvalid;
	logic             wready;
	mem_pkg::data_t   wdata;
	mem_pkg::strb_t   wstrb;

	// write response channel
	logic             bvalid;
	logic             bready;
	axi_pkg::resp_t   bresp;

	// read address channel
	logic             arvalid;
	logic             arready;
	mem_pkg::addr_t   araddr;

	// read data channel
	logic             rvalid;
	logic             rready;
	mem_pkg::data_t   rdata;
	axi_pkg::resp_t   rresp;

	modport master (
		output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

	modport slave (
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

endinterface

`default_nettype wire

// ==== hdl/axi_lite_master.sv ====
`default_nettype none

module axi_lite_master (
	input  wire logic       clk,
	input  wire logic       rst,
	mem_cmd_if.sink         cmd,
	axi_lite_if.master      axi,
	output logic            rsp_valid,
	input  wire logic       rsp_ready,
	output logic            rsp_we,
	output mem_pkg::data_t  rsp_rdata,
	output axi_pkg::resp_t  rsp_resp
);

	axi_pkg::master_state_t state;

	// channel valids, each cleared on its own handshake
	logic awvalid_q;
	logic wvalid_q;
	logic arvalid_q;

	// latched command
	logic           we_q;
	mem_pkg::addr_t addr_q;
	mem_pkg::data_t wdata_q;
	mem_pkg::strb_t wstrb_q;

	// latched response
	mem_pkg::data_t rdata_q;
	axi_pkg::resp_t resp_q;

	logic cmd_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire;
	logic r_fire;

	// only take a new command once the last response has gone
	assign cmd.ready = (state == axi_pkg::m_idle);
	assign cmd_fire  = cmd.valid && cmd.ready;

	// address shared by both channels
	assign axi.awvalid = awvalid_q;
	assign axi.awaddr  = addr_q;
	assign axi.wvalid  = wvalid_q;
	assign axi.wdata   = wdata_q;
	assign axi.wstrb   = wstrb_q;
	assign axi.arvalid = arvalid_q;
	assign axi.araddr  = addr_q;

	// response readies held for the whole wait
	assign axi.bready = (state == axi_pkg::m_write);
	assign axi.rready = (state == axi_pkg::m_read);

	assign aw_fire = awvalid_q && axi.awready;
	assign w_fire  = wvalid_q && axi.wready;
	assign b_fire  = axi.bvalid && axi.bready;
	assign ar_fire = arvalid_q && axi.arready;
	assign r_fire  = axi.rvalid && axi.rready;

	// client response port
	assign rsp_valid = (state == axi_pkg::m_resp);
	assign rsp_we    = we_q;
	assign rsp_rdata = rdata_q;
	assign rsp_resp  = resp_q;

	// payload capture
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			we_q    <= cmd.we;
			addr_q  <= cmd.addr;
			wdata_q <= cmd.wdata;
			wstrb_q <= cmd.wstrb;
		end
		// writes report zero data
		if (b_fire) begin
			resp_q  <= axi.bresp;
			rdata_q <= '0;
		end
		if (r_fire) begin
			resp_q  <= axi.rresp;
			rdata_q <= axi.rdata;
		end
	end

	// control FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= axi_pkg::m_idle;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
		end else begin
			case (state)
				axi_pkg::m_idle: begin
					if (cmd_fire) begin
						if (cmd.we) begin
							awvalid_q <= 1'b1;
							wvalid_q  <= 1'b1;
							state     <= axi_pkg::m_write;
						end else begin
							arvalid_q <= 1'b1;
							state     <= axi_pkg::m_read;
						end
					end
				end
				axi_pkg::m_write: begin
					// aw and w may be taken in different cycles
					if (aw_fire) begin
						awvalid_q <= 1'b0;
					end
					if (w_fire) begin
						wvalid_q <= 1'b0;
					end
					if (b_fire) begin
						state <= axi_pkg::m_resp;
					end
				end
				axi_pkg::m_read: begin
					if (ar_fire) begin
						arvalid_q <= 1'b0;
					end
					if (r_fire) begin
						state <= axi_pkg::m_resp;
					end
				end
				axi_pkg::m_resp: begin
					if (rsp_ready) begin
						state <= axi_pkg::m_idle;
					end
				end
				default: state <= axi_pkg::m_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/axi_lite_sram.sv ====
`default_nettype none

module axi_lite_sram (
	input  wire logic  clk,
	input  wire logic  rst,
	axi_lite_if.slave  axi
);

	// first byte address past the array
	localparam mem_pkg::addr_t ADDR_LIMIT = mem_pkg::addr_t'(mem_pkg::MEM_WORDS * 8);

	// byte lanes per word
	localparam int LANES = $bits(mem_pkg::strb_t);

	mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

	axi_pkg::slave_wr_state_t wr_state;
	axi_pkg::slave_rd_state_t rd_state;

	// write side decode
	logic                wr_fire;
	logic                wr_in_range;
	mem_pkg::word_idx_t  wr_idx;

	// read side decode
	logic                rd_fire;
	logic                rd_in_range;
	mem_pkg::word_idx_t  rd_idx;

	// bits 2:0 are ignored
	assign wr_idx      = axi.awaddr[3 +: $bits(mem_pkg::word_idx_t)];
	assign wr_in_range = (axi.awaddr < ADDR_LIMIT);
	assign rd_idx      = axi.araddr[3 +: $bits(mem_pkg::word_idx_t)];
	assign rd_in_range = (axi.araddr < ADDR_LIMIT);

	// address and data are taken together, never one alone
	assign axi.awready = (wr_state == axi_pkg::wr_idle) && axi.awvalid && axi.wvalid;
	assign axi.wready  = axi.awready;
	assign wr_fire     = axi.awready;
	assign axi.bvalid  = (wr_state == axi_pkg::wr_resp);

	assign axi.arready = (rd_state == axi_pkg::rd_idle);
	assign rd_fire     = axi.arvalid && axi.arready;
	assign axi.rvalid  = (rd_state == axi_pkg::rd_resp);

	// byte-masked array write
	always_ff @(posedge clk) begin
		if (wr_fire && wr_in_range) begin
			for (int i = 0; i < LANES; i++) begin
				if (axi.wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= axi.wdata[i*8 +: 8];
				end
			end
		end
	end

	// write response code
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			axi.bresp <= wr_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
		end
	end

	// write channel FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= axi_pkg::wr_idle;
		end else begin
			case (wr_state)
				axi_pkg::wr_idle: begin
					if (wr_fire) begin
						wr_state <= axi_pkg::wr_resp;
					end
				end
				axi_pkg::wr_resp: begin
					if (axi.bready) begin
						wr_state <= axi_pkg::wr_idle;
					end
				end
				default: wr_state <= axi_pkg::wr_idle;
			endcase
		end
	end

	// registered read data, zero outside the array
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			if (rd_in_range) begin
				axi.rdata <= mem[rd_idx];
				axi.rresp <= axi_pkg::RESP_OKAY;
			end else begin
				axi.rdata <= '0;
				axi.rresp <= axi_pkg::RESP_SLVERR;
			end
		end
	end

	// read channel FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= axi_pkg::rd_idle;
		end else begin
			case (rd_state)
				axi_pkg::rd_idle: begin
					if (rd_fire) begin
						rd_state <= axi_pkg::rd_resp;
					end
				end
				axi_pkg::rd_resp: begin
					if (axi.rready) begin
						rd_state <= axi_pkg::rd_idle;
					end
				end
				default: rd_state <= axi_pkg::rd_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

	// AXI4-Lite response code
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// bridge FSM
	typedef enum logic [1:0] {
		m_idle,
		m_write,
		m_read,
		m_resp
	} master_state_t;

	// slave write channel FSM
	typedef enum logic {
		wr_idle,
		wr_resp
	} slave_wr_state_t;

	// slave read channel FSM
	typedef enum logic {
		rd_idle,
		rd_resp
	} slave_rd_state_t;

endpackage

`default_nettype wire

// ==== hdl/cmd_fifo.sv ====
`default_nettype none

module cmd_fifo #(
	parameter int DEPTH = mem_pkg::CMD_FIFO_DEPTH
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            in_valid,
	output logic                 in_ready,
	input  wire logic            in_we,
	input  wire mem_pkg::addr_t  in_addr,
	input  wire mem_pkg::data_t  in_wdata,
	input  wire mem_pkg::strb_t  in_wstrb,
	mem_cmd_if.source            out
);

	// pointer and occupancy widths
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// storage, one array per field
	logic           we_mem    [DEPTH];
	mem_pkg::addr_t addr_mem  [DEPTH];
	mem_pkg::data_t wdata_mem [DEPTH];
	mem_pkg::strb_t wstrb_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic full;
	logic push;
	logic pop;

	// circular increment
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));

	// a full queue still takes a command when one leaves in the same cycle
	assign in_ready = !full || out.ready;

	assign push = in_valid && in_ready;
	assign pop  = out.valid && out.ready;

	// head entry goes straight out
	assign out.valid = (count != '0);
	assign out.we    = we_mem[rd_ptr];
	assign out.addr  = addr_mem[rd_ptr];
	assign out.wdata = wdata_mem[rd_ptr];
	assign out.wstrb = wstrb_mem[rd_ptr];

	// entry write
	always_ff @(posedge clk) begin
		if (push) begin
			we_mem[wr_ptr]    <= in_we;
			addr_mem[wr_ptr]  <= in_addr;
			wdata_mem[wr_ptr] <= in_wdata;
			wstrb_mem[wr_ptr] <= in_wstrb;
		end
	end

	// pointers and count
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mem_cmd_if.sv ====
`default_nettype none

interface mem_cmd_if;

	// handshake
	logic           valid;
	logic           ready;

	// command payload, stable while valid waits for ready
	logic           we;
	mem_pkg::addr_t addr;
	mem_pkg::data_t wdata;
	mem_pkg::strb_t wstrb;

	modport source (
		output valid, we, addr, wdata, wstrb,
		input  ready
	);

	modport sink (
		input  valid, we, addr, wdata, wstrb,
		output ready
	);

endinterface

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// byte address as seen by the client
	typedef logic [31:0] addr_t;

	// one memory word
	typedef logic [63:0] data_t;

	// one enable bit per data byte
	typedef logic [7:0] strb_t;

	// array size in 64-bit words
	localparam int MEM_WORDS = 1024;

	// index into the word array
	typedef logic [9:0] word_idx_t;

	// default number of queued commands
	localparam int CMD_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
`default_nettype none

module mem_subsys_top (
	input  wire logic            clk,
	input  wire logic            rst,

	// command side
	input  wire logic            cmd_valid,
	output logic                 cmd_ready,
	input  wire logic            cmd_we,
	input  wire mem_pkg::addr_t  cmd_addr,
	input  wire mem_pkg::data_t  cmd_wdata,
	input  wire mem_pkg::strb_t  cmd_wstrb,

	// response side
	output logic                 rsp_valid,
	input  wire logic            rsp_ready,
	output logic                 rsp_we,
	output mem_pkg::data_t       rsp_rdata,
	output axi_pkg::resp_t       rsp_resp
);

	// queue to bridge
	mem_cmd_if cmd_bus ();

	// bridge to memory
	axi_lite_if axi_bus ();

	cmd_fifo #(
		.DEPTH (mem_pkg::CMD_FIFO_DEPTH)
	) cmd_fifo_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (cmd_valid),
		.in_ready (cmd_ready),
		.in_we    (cmd_we),
		.in_addr  (cmd_addr),
		.in_wdata (cmd_wdata),
		.in_wstrb (cmd_wstrb),
		.out      (cmd_bus.source)
	);

	axi_lite_master master_i (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd_bus.sink),
		.axi       (axi_bus.master),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_we    (rsp_we),
		.rsp_rdata (rsp_rdata),
		.rsp_resp  (rsp_resp)
	);

	axi_lite_sram sram_i (
		.clk (clk),
		.rst (rst),
		.axi (axi_bus.slave)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --Mdir obj_dir \
	--top-module mem_subsys_tb -f files.f -o mem_subsys_sim \
	&& ./obj_dir/mem_subsys_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

// ==== test/mem_subsys_sva.sv ====
`default_nettype none

module mem_subsys_sva (
	input wire logic           clk,
	input wire logic           rst,
	input wire logic           rsp_valid,
	input wire logic           rsp_ready,
	input wire logic           rsp_we,
	input wire mem_pkg::data_t rsp_rdata,
	input wire axi_pkg::resp_t rsp_resp,
	input wire logic           awvalid,
	input wire logic           awready,
	input wire mem_pkg::addr_t awaddr,
	input wire logic           wvalid,
	input wire logic           wready,
	input wire mem_pkg::data_t wdata,
	input wire mem_pkg::strb_t wstrb,
	input wire logic           bvalid,
	input wire logic           bready,
	input wire axi_pkg::resp_t bresp,
	input wire logic           arvalid,
	input wire logic           arready,
	input wire mem_pkg::addr_t araddr,
	input wire logic           rvalid,
	input wire logic           rready,
	input wire mem_pkg::data_t rdata,
	input wire axi_pkg::resp_t rresp
);

	// client response beat waits for rsp_ready
	rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_we, rsp_rdata, rsp_resp}))
		else $error("rsp_valid dropped or response payload changed before rsp_ready");

	// write address and write data
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid dropped or awaddr changed before awready");
	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
		else $error("wvalid dropped or write data changed before wready");

	// write response
	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	// read address and read data
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr changed before arready");
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable({rdata, rresp}))
		else $error("rvalid dropped or read data changed before rready");

	// nothing pending right after reset
	reset_quiet: assert property (@(posedge clk)
		rst |=> !rsp_valid && !awvalid && !wvalid && !arvalid && !bvalid && !rvalid)
		else $error("a valid is high in the cycle after reset");

endmodule

// internal AXI channels are reached through the interface instance
bind mem_subsys_top mem_subsys_sva sva_i (
	.clk       (clk),
	.rst       (rst),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_we    (rsp_we),
	.rsp_rdata (rsp_rdata),
	.rsp_resp  (rsp_resp),
	.awvalid   (axi_bus.awvalid),
	.awready   (axi_bus.awready),
	.awaddr    (axi_bus.awaddr),
	.wvalid    (axi_bus.wvalid),
	.wready    (axi_bus.wready),
	.wdata     (axi_bus.wdata),
	.wstrb     (axi_bus.wstrb),
	.bvalid    (axi_bus.bvalid),
	.bready    (axi_bus.bready),
	.bresp     (axi_bus.bresp),
	.arvalid   (axi_bus.arvalid),
	.arready   (axi_bus.arready),
	.araddr    (axi_bus.araddr),
	.rvalid    (axi_bus.rvalid),
	.rready    (axi_bus.rready),
	.rdata     (axi_bus.rdata),
	.rresp     (axi_bus.rresp)
);

`default_nettype wire

// ==== test/mem_subsys_tb.sv ====
`default_nettype none

module mem_subsys_tb;

	// working words written before any read
	localparam int WORK_WORDS    = 16;
	localparam int RANDOM_CMDS   = 200;
	// upper bound on the directed commands
	localparam int DIRECTED_CMDS = 40;
	localparam int TOTAL_CMDS    = WORK_WORDS + DIRECTED_CMDS + RANDOM_CMDS;
	localparam int WATCHDOG_CYC  = TOTAL_CMDS * 40 + 200;
	// first byte address outside the memory
	localparam mem_pkg::addr_t ADDR_LIMIT = mem_pkg::addr_t'(mem_pkg::MEM_WORDS * 8);

	typedef struct packed {
		logic           we;
		axi_pkg::resp_t resp;
		mem_pkg::data_t rdata;
	} rsp_t;

	logic           clk = 1'b0;
	logic           rst;
	logic           cmd_valid;
	logic           cmd_ready;
	logic           cmd_we;
	mem_pkg::addr_t cmd_addr;
	mem_pkg::data_t cmd_wdata;
	mem_pkg::strb_t cmd_wstrb;
	logic           rsp_valid;
	logic           rsp_ready;
	logic           rsp_we;
	mem_pkg::data_t rsp_rdata;
	axi_pkg::resp_t rsp_resp;

	integer         seed;
	int             errors;
	// 0 always ready, 1 held low, 2 random stalls
	int             stall_mode;
	logic [31:0]    ready_draw;

	// shadow of the word array and the responses still owed
	mem_pkg::data_t shadow [mem_pkg::MEM_WORDS];
	rsp_t           exp_q [$];

	mem_subsys_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_we    (cmd_we),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.cmd_wstrb (cmd_wstrb),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_we    (rsp_we),
		.rsp_rdata (rsp_rdata),
		.rsp_resp  (rsp_resp)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
			errors++;
		end
	endtask

	// fill pattern built from the whole address
	function automatic mem_pkg::data_t fill_word(input mem_pkg::addr_t addr);
		return {addr ^ 32'hc3a5_0f69, ~addr};
	endfunction

	function automatic mem_pkg::data_t random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// applies the memory rule to the shadow and queues the result in command order
	function automatic void predict(input logic we, input mem_pkg::addr_t addr,
			input mem_pkg::data_t wdata, input mem_pkg::strb_t wstrb);
		rsp_t               exp;
		mem_pkg::word_idx_t idx;
		exp.we    = we;
		exp.rdata = '0;
		if (addr >= ADDR_LIMIT) begin
			// dropped write or zero read
			exp.resp = axi_pkg::RESP_SLVERR;
		end else begin
			exp.resp = axi_pkg::RESP_OKAY;
			idx      = mem_pkg::word_idx_t'(addr / 8);
			if (we) begin
				for (int b = 0; b < 8; b++) begin
					if (wstrb[b]) begin
						shadow[idx][b*8 +: 8] = wdata[b*8 +: 8];
					end
				end
			end else begin
				exp.rdata = shadow[idx];
			end
		end
		exp_q.push_back(exp);
	endfunction

	// runs from just after a rising edge until just after the accepting edge
	task automatic send_cmd(input logic we, input mem_pkg::addr_t addr,
			input mem_pkg::data_t wdata, input mem_pkg::strb_t wstrb);
		cmd_valid = 1'b1;
		cmd_we    = we;
		cmd_addr  = addr;
		cmd_wdata = wdata;
		cmd_wstrb = wstrb;
		@(posedge clk);
		while (!cmd_ready) begin
			@(posedge clk);
		end
		#1;
		cmd_valid = 1'b0;
	endtask

	// wait for all outstanding responses
	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// stall pattern drawn on the falling edge
	always @(negedge clk) begin
		ready_draw = $random(seed);
	end

	initial begin
		int mode;
		rsp_ready = 1'b1;
		forever begin
			@(posedge clk);
			// stall mode sampled on the edge
			mode = stall_mode;
			#1;
			case (mode)
				0: rsp_ready = 1'b1;
				1: rsp_ready = 1'b0;
				default: rsp_ready = (ready_draw[1:0] != 2'b00);
			endcase
		end
	end

	// accepted commands feed the model and accepted responses get checked
	always @(posedge clk) begin
		rsp_t exp;
		if (!rst) begin
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("error at %0t: response with no command outstanding", $time);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					check_value("rsp_we", 64'(exp.we), 64'(rsp_we));
					check_value("rsp_resp", 64'(exp.resp), 64'(rsp_resp));
					check_value("rsp_rdata", exp.rdata, rsp_rdata);
				end
			end
			if (cmd_valid && cmd_ready) begin
				predict(cmd_we, cmd_addr, cmd_wdata, cmd_wstrb);
			end
		end
	end

	initial begin
		logic [31:0]    draw;
		mem_pkg::addr_t addr;
		seed       = 32'h80ba;
		errors     = 0;
		stall_mode = 0;
		rst        = 1'b1;
		cmd_valid  = 1'b0;
		cmd_we     = 1'b0;
		cmd_addr   = '0;
		cmd_wdata  = '0;
		cmd_wstrb  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// idle right after reset
		check_value("rsp_valid", 64'd0, 64'(rsp_valid));
		check_value("cmd_ready", 64'd1, 64'(cmd_ready));

		// fill the working words then one write and its read back
		for (int w = 0; w < WORK_WORDS; w++) begin
			send_cmd(1'b1, 32'(w * 8), fill_word(32'(w * 8)), 8'hff);
		end
		send_cmd(1'b1, 32'h40, 64'h0123_4567_89ab_cdef, 8'hff);
		send_cmd(1'b0, 32'h40, '0, '0);
		drain();

		// byte merge on word 5 with low address bits set on the last read
		for (int i = 0; i < 6; i++) begin
			send_cmd(1'b1, 32'h28, random_word(), 8'($random(seed)));
			send_cmd(1'b0, 32'h28, '0, '0);
		end
		send_cmd(1'b0, 32'h2f, '0, '0);
		drain();

		// out of range accesses and the word 3 alias
		send_cmd(1'b1, ADDR_LIMIT + 32'h18, 64'hdead_beef_dead_beef, 8'hff);
		send_cmd(1'b0, ADDR_LIMIT + 32'h18, '0, '0);
		send_cmd(1'b0, 32'h18, '0, '0);
		send_cmd(1'b1, 32'hffff_fff8, random_word(), 8'hff);
		send_cmd(1'b0, 32'hffff_fff8, '0, '0);
		drain();

		// one command in the bridge plus a full queue
		stall_mode = 1;
		for (int i = 0; i < mem_pkg::CMD_FIFO_DEPTH + 1; i++) begin
			send_cmd(i % 2 == 0, 32'((i % WORK_WORDS) * 8), random_word(), 8'hff);
		end
		repeat (3) @(posedge clk);
		#1;
		check_value("cmd_ready", 64'd0, 64'(cmd_ready));
		stall_mode = 0;
		send_cmd(1'b0, 32'h0, '0, '0);
		drain();

		// random mix with a few addresses past the end
		stall_mode = 2;
		for (int i = 0; i < RANDOM_CMDS; i++) begin
			draw = $random(seed);
			addr = (draw % WORK_WORDS) * 8;
			if (draw[7:4] == 4'd0) begin
				addr = addr + ADDR_LIMIT;
			end
			send_cmd(draw[8], addr, random_word(), 8'($random(seed)));
		end
		stall_mode = 0;
		drain();

		$display("closing: %0d errors, %0d responses outstanding", errors, exp_q.size());
		if (errors == 0 && exp_q.size() == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog bound from the command count
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("closing: %0d errors, %0d responses outstanding", errors, exp_q.size());
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
